/* Bender.yml */
package:
  name: load_store_unit

sources:
  - src/lsu_pkg.sv
  - src/lsu_agu.sv
  - src/lsu_req_queue.sv
  - src/lsu_mem_port.sv
  - src/lsu_result_pipe.sv
  - src/load_store_unit.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/lsu_checker.sv
      - test/tb_top.sv

/* src/load_store_unit.sv */
// --------------------
// Load/store unit top level
// AGU, request queue, memory port and
// the load and store result pipes
// --------------------

`timescale 1ns/10ps

module load_store_unit #(
  // Output register stages per stream, 0 to 4
  parameter int ResultPipeDepth = 1
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               lsu_valid_i,
  input  lsu_pkg::lsu_op_e   lsu_op_i,
  input  lsu_pkg::xlen_t     operand_a_i,
  input  lsu_pkg::xlen_t     imm_i,
  input  lsu_pkg::xlen_t     store_data_i,
  input  lsu_pkg::trans_id_t trans_id_i,
  output logic               lsu_ready_o,
  output logic               mem_req_o,
  input  logic               mem_ack_i,
  output lsu_pkg::xlen_t     mem_addr_o,
  output lsu_pkg::xlen_t     mem_wdata_o,
  output logic               mem_we_o,
  output lsu_pkg::be_t       mem_be_o,
  input  lsu_pkg::xlen_t     mem_rdata_i,
  output logic               load_valid_o,
  output lsu_pkg::trans_id_t load_trans_id_o,
  output lsu_pkg::xlen_t     load_result_o,
  output logic               load_exception_o,
  output lsu_pkg::cause_t    load_cause_o,
  output logic               store_valid_o,
  output lsu_pkg::trans_id_t store_trans_id_o,
  output logic               store_exception_o,
  output lsu_pkg::cause_t    store_cause_o
);

  localparam int LdWidth = 2 + lsu_pkg::TRANS_ID_BITS + lsu_pkg::XLEN + $bits(lsu_pkg::cause_t);
  localparam int StWidth = 2 + lsu_pkg::TRANS_ID_BITS + $bits(lsu_pkg::cause_t);

  lsu_pkg::xlen_t     agu_vaddr;
  lsu_pkg::be_t       agu_be;
  logic               agu_misaligned;

  logic               head_valid;
  lsu_pkg::lsu_op_e   head_op;
  lsu_pkg::xlen_t     head_vaddr;
  lsu_pkg::xlen_t     head_wdata;
  lsu_pkg::be_t       head_be;
  logic               head_misaligned;
  lsu_pkg::trans_id_t head_trans_id;
  logic               pop;

  logic               res_valid;
  logic               res_is_load;
  lsu_pkg::trans_id_t res_trans_id;
  lsu_pkg::xlen_t     res_data;
  logic               res_exception;
  lsu_pkg::cause_t    res_cause;

  lsu_agu i_agu (
    .lsu_op_i     (lsu_op_i),
    .operand_a_i  (operand_a_i),
    .imm_i        (imm_i),
    .vaddr_o      (agu_vaddr),
    .be_o         (agu_be),
    .misaligned_o (agu_misaligned)
  );

  lsu_req_queue i_req_queue (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .push_i            (lsu_valid_i),
    .op_i              (lsu_op_i),
    .vaddr_i           (agu_vaddr),
    .wdata_i           (store_data_i),
    .be_i              (agu_be),
    .misaligned_i      (agu_misaligned),
    .trans_id_i        (trans_id_i),
    .ready_o           (lsu_ready_o),
    .head_valid_o      (head_valid),
    .head_op_o         (head_op),
    .head_vaddr_o      (head_vaddr),
    .head_wdata_o      (head_wdata),
    .head_be_o         (head_be),
    .head_misaligned_o (head_misaligned),
    .head_trans_id_o   (head_trans_id),
    .pop_i             (pop)
  );

  lsu_mem_port i_mem_port (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .head_valid_i      (head_valid),
    .head_op_i         (head_op),
    .head_vaddr_i      (head_vaddr),
    .head_wdata_i      (head_wdata),
    .head_be_i         (head_be),
    .head_misaligned_i (head_misaligned),
    .head_trans_id_i   (head_trans_id),
    .pop_o             (pop),
    .mem_req_o         (mem_req_o),
    .mem_ack_i         (mem_ack_i),
    .mem_addr_o        (mem_addr_o),
    .mem_we_o          (mem_we_o),
    .mem_be_o          (mem_be_o),
    .mem_wdata_o       (mem_wdata_o),
    .mem_rdata_i       (mem_rdata_i),
    .res_valid_o       (res_valid),
    .res_is_load_o     (res_is_load),
    .res_trans_id_o    (res_trans_id),
    .res_data_o        (res_data),
    .res_exception_o   (res_exception),
    .res_cause_o       (res_cause)
  );

  // --------------------
  // Output pipelines
  // --------------------
  // Equal depth on both streams keeps results in acceptance order
  lsu_result_pipe #(
    .Width (LdWidth),
    .Depth (ResultPipeDepth)
  ) i_load_pipe (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .d_i    ({res_valid && res_is_load, res_trans_id, res_data, res_exception, res_cause}),
    .d_o    ({load_valid_o, load_trans_id_o, load_result_o, load_exception_o, load_cause_o})
  );

  lsu_result_pipe #(
    .Width (StWidth),
    .Depth (ResultPipeDepth)
  ) i_store_pipe (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .d_i    ({res_valid && !res_is_load, res_trans_id, res_exception, res_cause}),
    .d_o    ({store_valid_o, store_trans_id_o, store_exception_o, store_cause_o})
  );

endmodule

/* src/lsu_agu.sv */
// --------------------
// Address generation unit
// Effective address, byte enables and
// misalignment flag for the issued operation
// --------------------

`timescale 1ns/10ps

module lsu_agu (
  input  lsu_pkg::lsu_op_e lsu_op_i,
  input  lsu_pkg::xlen_t   operand_a_i,
  input  lsu_pkg::xlen_t   imm_i,
  output lsu_pkg::xlen_t   vaddr_o,
  output lsu_pkg::be_t     be_o,
  output logic             misaligned_o
);

  // Access size as log2 of the byte count
  logic [1:0] size;
  logic [1:0] offset;

  // Base plus sign-extended immediate
  assign vaddr_o = $unsigned($signed(operand_a_i) + $signed(imm_i));
  assign offset  = vaddr_o[1:0];

  always_comb begin
    case (lsu_op_i)
      lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH: size = 2'd1;
      lsu_pkg::LW, lsu_pkg::SW:               size = 2'd2;
      default:                                size = 2'd0;
    endcase
  end

  // --------------------
  // Byte enable and alignment
  // --------------------
  always_comb begin
    be_o         = '0;
    misaligned_o = 1'b0;
    case (size)
      2'd2: begin
        be_o         = 4'b1111;
        misaligned_o = (offset != 2'b00);
      end
      2'd1: begin
        // Lanes past bit 3 fall off for a misaligned halfword
        be_o         = 4'b0011 << offset;
        misaligned_o = offset[0];
      end
      default: begin
        // Bytes are always aligned
        be_o = 4'b0001 << offset;
      end
    endcase
  end

endmodule

/* src/lsu_mem_port.sv */
// --------------------
// Memory access port
// Four-phase req/ack FSM, store lane placement,
// load extraction and misaligned bypass
// --------------------

`timescale 1ns/10ps

module lsu_mem_port (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               head_valid_i,
  input  lsu_pkg::lsu_op_e   head_op_i,
  input  lsu_pkg::xlen_t     head_vaddr_i,
  input  lsu_pkg::xlen_t     head_wdata_i,
  input  lsu_pkg::be_t       head_be_i,
  input  logic               head_misaligned_i,
  input  lsu_pkg::trans_id_t head_trans_id_i,
  output logic               pop_o,
  output logic               mem_req_o,
  input  logic               mem_ack_i,
  output lsu_pkg::xlen_t     mem_addr_o,
  output logic               mem_we_o,
  output lsu_pkg::be_t       mem_be_o,
  output lsu_pkg::xlen_t     mem_wdata_o,
  input  lsu_pkg::xlen_t     mem_rdata_i,
  output logic               res_valid_o,
  output logic               res_is_load_o,
  output lsu_pkg::trans_id_t res_trans_id_o,
  output lsu_pkg::xlen_t     res_data_o,
  output logic               res_exception_o,
  output lsu_pkg::cause_t    res_cause_o
);

  lsu_pkg::mem_state_e state_q, state_d;

  logic               is_load;
  logic [4:0]         lane_shift;
  lsu_pkg::xlen_t     rdata_shifted;
  lsu_pkg::xlen_t     load_data;
  logic               finish;

  logic               res_valid_q;
  logic               res_is_load_q;
  lsu_pkg::trans_id_t res_trans_id_q;
  lsu_pkg::xlen_t     res_data_q;
  logic               res_exception_q;
  lsu_pkg::cause_t    res_cause_q;

  assign is_load    = head_op_i inside {lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::LH,
                                        lsu_pkg::LHU, lsu_pkg::LW};
  assign lane_shift = {head_vaddr_i[1:0], 3'b000};

  // --------------------
  // Memory request
  // --------------------
  // Head fields hold until pop, so the request stays stable
  assign mem_req_o   = (state_q == lsu_pkg::WAIT_ACK);
  assign mem_addr_o  = {head_vaddr_i[lsu_pkg::XLEN-1:2], 2'b00};
  assign mem_we_o    = !is_load;
  assign mem_be_o    = head_be_i;
  assign mem_wdata_o = head_wdata_i << lane_shift;

  // --------------------
  // Load data alignment
  // --------------------
  assign rdata_shifted = mem_rdata_i >> lane_shift;

  always_comb begin
    case (head_op_i)
      lsu_pkg::LB:  load_data = {{24{rdata_shifted[7]}}, rdata_shifted[7:0]};
      lsu_pkg::LBU: load_data = {24'b0, rdata_shifted[7:0]};
      lsu_pkg::LH:  load_data = {{16{rdata_shifted[15]}}, rdata_shifted[15:0]};
      lsu_pkg::LHU: load_data = {16'b0, rdata_shifted[15:0]};
      default:      load_data = rdata_shifted;
    endcase
  end

  // --------------------
  // Handshake FSM
  // --------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      lsu_pkg::IDLE: begin
        // Misaligned heads skip memory but still pass WAIT_RELEASE,
        // which blanks the head for the pop cycle
        if (head_valid_i) begin
          state_d = head_misaligned_i ? lsu_pkg::WAIT_RELEASE : lsu_pkg::WAIT_ACK;
        end
      end
      lsu_pkg::WAIT_ACK: begin
        if (mem_ack_i) begin
          state_d = lsu_pkg::WAIT_RELEASE;
        end
      end
      lsu_pkg::WAIT_RELEASE: begin
        if (!mem_ack_i) begin
          state_d = lsu_pkg::IDLE;
        end
      end
      default: state_d = lsu_pkg::IDLE;
    endcase
  end

  assign finish = ((state_q == lsu_pkg::IDLE) && head_valid_i && head_misaligned_i) ||
                  ((state_q == lsu_pkg::WAIT_ACK) && mem_ack_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= lsu_pkg::IDLE;
      res_valid_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      res_valid_q <= finish;
    end
  end

  // Misaligned accesses report their address as the result
  always_ff @(posedge clk_i) begin
    if (finish) begin
      res_is_load_q   <= is_load;
      res_trans_id_q  <= head_trans_id_i;
      res_exception_q <= head_misaligned_i;
      if (head_misaligned_i) begin
        res_data_q  <= head_vaddr_i;
        res_cause_q <= is_load ? lsu_pkg::CAUSE_LD_MISALIGNED : lsu_pkg::CAUSE_ST_MISALIGNED;
      end else begin
        res_data_q  <= is_load ? load_data : '0;
        res_cause_q <= '0;
      end
    end
  end

  // The head is retired in the same cycle as its result strobe
  assign pop_o           = res_valid_q;
  assign res_valid_o     = res_valid_q;
  assign res_is_load_o   = res_is_load_q;
  assign res_trans_id_o  = res_trans_id_q;
  assign res_data_o      = res_data_q;
  assign res_exception_o = res_exception_q;
  assign res_cause_o     = res_cause_q;

endmodule

/* src/lsu_pkg.sv */
// --------------------
// Shared definitions for the load/store unit
// Widths, vector types, cause codes,
// operation and memory FSM encodings
// --------------------

package lsu_pkg;

  localparam int XLEN          = 32;
  localparam int TRANS_ID_BITS = 3;

  typedef logic [XLEN-1:0]          xlen_t;
  typedef logic [XLEN/8-1:0]        be_t;
  typedef logic [TRANS_ID_BITS-1:0] trans_id_t;
  typedef logic [4:0]               cause_t;

  // Exception causes in RISC-V numbering
  localparam cause_t CAUSE_LD_MISALIGNED = 5'd4;
  localparam cause_t CAUSE_ST_MISALIGNED = 5'd6;

  typedef enum logic [3:0] {
    LB  = 4'h0,
    LBU = 4'h1,
    LH  = 4'h2,
    LHU = 4'h3,
    LW  = 4'h4,
    SB  = 4'h8,
    SH  = 4'h9,
    SW  = 4'ha
  } lsu_op_e;

  // Four-phase handshake states of the memory port
  typedef enum logic [1:0] {
    IDLE         = 2'd0,
    WAIT_ACK     = 2'd1,
    WAIT_RELEASE = 2'd2
  } mem_state_e;

endpackage

/* src/lsu_req_queue.sv */
// --------------------
// Request queue
// Two-entry FIFO between issue and the
// memory port, drives the issue ready
// --------------------

`timescale 1ns/10ps

module lsu_req_queue (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                push_i,
  input  lsu_pkg::lsu_op_e    op_i,
  input  lsu_pkg::xlen_t      vaddr_i,
  input  lsu_pkg::xlen_t      wdata_i,
  input  lsu_pkg::be_t        be_i,
  input  logic                misaligned_i,
  input  lsu_pkg::trans_id_t  trans_id_i,
  output logic                ready_o,
  output logic                head_valid_o,
  output lsu_pkg::lsu_op_e    head_op_o,
  output lsu_pkg::xlen_t      head_vaddr_o,
  output lsu_pkg::xlen_t      head_wdata_o,
  output lsu_pkg::be_t        head_be_o,
  output logic                head_misaligned_o,
  output lsu_pkg::trans_id_t  head_trans_id_o,
  input  logic                pop_i
);

  lsu_pkg::lsu_op_e   op_q         [2];
  lsu_pkg::xlen_t     vaddr_q      [2];
  lsu_pkg::xlen_t     wdata_q      [2];
  lsu_pkg::be_t       be_q         [2];
  logic               misaligned_q [2];
  lsu_pkg::trans_id_t trans_id_q   [2];

  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic       push;

  assign ready_o      = (count_q != 2'd2);
  assign head_valid_o = (count_q != 2'd0);
  // Only accepted operations are written
  assign push         = push_i && ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop_i) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      case ({push, pop_i})
        2'b10:   count_q <= count_q + 2'd1;
        2'b01:   count_q <= count_q - 2'd1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      op_q[wr_ptr_q]         <= op_i;
      vaddr_q[wr_ptr_q]      <= vaddr_i;
      wdata_q[wr_ptr_q]      <= wdata_i;
      be_q[wr_ptr_q]         <= be_i;
      misaligned_q[wr_ptr_q] <= misaligned_i;
      trans_id_q[wr_ptr_q]   <= trans_id_i;
    end
  end

  assign head_op_o         = op_q[rd_ptr_q];
  assign head_vaddr_o      = vaddr_q[rd_ptr_q];
  assign head_wdata_o      = wdata_q[rd_ptr_q];
  assign head_be_o         = be_q[rd_ptr_q];
  assign head_misaligned_o = misaligned_q[rd_ptr_q];
  assign head_trans_id_o   = trans_id_q[rd_ptr_q];

endmodule

/* src/lsu_result_pipe.sv */
// --------------------
// Result pipeline
// Depth-stage register chain for one result stream
// --------------------

`timescale 1ns/10ps

module lsu_result_pipe #(
  parameter int Width = 1,
  parameter int Depth = 1
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [Width-1:0] d_i,
  output logic [Width-1:0] d_o
);

  if (Depth == 0) begin : gen_bypass
    assign d_o = d_i;
  end else begin : gen_regs
    logic [Width-1:0] stage_q [Depth];

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        for (int i = 0; i < Depth; i++) begin
          stage_q[i] <= '0;
        end
      end else begin
        stage_q[0] <= d_i;
        // Every stage moves each cycle, so several results can be in flight
        for (int i = 1; i < Depth; i++) begin
          stage_q[i] <= stage_q[i-1];
        end
      end
    end

    assign d_o = stage_q[Depth-1];
  end

endmodule

/* tb.f */
src/lsu_pkg.sv
src/lsu_agu.sv
src/lsu_req_queue.sv
src/lsu_mem_port.sv
src/lsu_result_pipe.sv
src/load_store_unit.sv
test/tb_clock_gen.sv
test/lsu_checker.sv
test/tb_top.sv

/* test/lsu_checker.sv */
// --------------------
// Protocol checker for the load/store unit
// Reset values, issue acceptance, misaligned
// bypass and four-phase memory handshake
// --------------------

`timescale 1ns/10ps

module lsu_checker (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 lsu_valid_i,
  input logic                 lsu_ready_i,
  input logic                 pop_i,
  input logic                 head_valid_i,
  input logic                 head_misaligned_i,
  input logic                 mem_req_i,
  input logic                 mem_ack_i,
  input lsu_pkg::xlen_t       mem_addr_i,
  input logic                 mem_we_i,
  input lsu_pkg::be_t         mem_be_i,
  input lsu_pkg::xlen_t       mem_wdata_i,
  input logic                 load_valid_i,
  input logic                 store_valid_i
);

  // Read by the testbench top to end the run
  int unsigned fail_count = 0;

  // Outputs idle and issue side open while in reset
  reset_values_a: assert property (@(posedge clk_i)
    !rst_ni |-> !load_valid_i && !store_valid_i && !mem_req_i && lsu_ready_i)
    else begin
      $error("Outputs not at reset values");
      fail_count++;
    end

  // A full queue only drains through a pop, so nothing is taken while not ready
  no_accept_when_full_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lsu_valid_i && !lsu_ready_i && !pop_i |=> !lsu_ready_i)
    else begin
      $error("Operation accepted while the queue was full");
      fail_count++;
    end

  misaligned_no_request_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    head_valid_i && head_misaligned_i |-> !mem_req_i)
    else begin
      $error("Memory request issued for a misaligned access");
      fail_count++;
    end

  // --------------------
  // Four-phase handshake
  // --------------------
  req_held_until_ack_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_i && !mem_ack_i |=> mem_req_i)
    else begin
      $error("Request dropped before ack");
      fail_count++;
    end

  req_falls_after_ack_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(mem_req_i) |-> $past(mem_ack_i))
    else begin
      $error("Request fell without a preceding ack");
      fail_count++;
    end

  req_rises_with_ack_low_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(mem_req_i) |-> !$past(mem_ack_i))
    else begin
      $error("Request raised while ack was still high");
      fail_count++;
    end

  req_fields_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_i && $past(mem_req_i) |->
      $stable(mem_addr_i) && $stable(mem_be_i) && $stable(mem_wdata_i) && $stable(mem_we_i))
    else begin
      $error("Request fields changed while request was high");
      fail_count++;
    end

endmodule

bind load_store_unit lsu_checker i_lsu_checker (
  .clk_i             (clk_i),
  .rst_ni            (rst_ni),
  .lsu_valid_i       (lsu_valid_i),
  .lsu_ready_i       (lsu_ready_o),
  .pop_i             (pop),
  .head_valid_i      (head_valid),
  .head_misaligned_i (head_misaligned),
  .mem_req_i         (mem_req_o),
  .mem_ack_i         (mem_ack_i),
  .mem_addr_i        (mem_addr_o),
  .mem_we_i          (mem_we_o),
  .mem_be_i          (mem_be_o),
  .mem_wdata_i       (mem_wdata_o),
  .load_valid_i      (load_valid_o),
  .store_valid_i     (store_valid_o)
);

/* test/tb_clock_gen.sv */
// --------------------
// Testbench clock and reset
// 4 ns clock, reset held low for 5 cycles
// --------------------

`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (5) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

/* test/tb_top.sv */
// --------------------
// Load/store unit testbench
// Directed and random stimulus, four-phase memory
// model, reference model and result comparison
// --------------------

`timescale 1ns/10ps

module tb_top;

  localparam int NUM_OPS        = 250;
  localparam int MAX_ACK_DELAY  = 3;
  localparam int MEM_WORDS      = 64;
  localparam int PIPE_DEPTH     = 2;
  localparam int TIMEOUT_CYCLES = NUM_OPS * 20 + 100;

  typedef struct packed {
    logic               is_load;
    lsu_pkg::trans_id_t tag;
    lsu_pkg::xlen_t     data;
    logic               exception;
    lsu_pkg::cause_t    cause;
  } expect_t;

  logic clk_i;
  logic rst_ni;
  logic lsu_valid_i;
  logic lsu_ready_o;
  logic mem_req_o;
  logic mem_ack_i;
  logic mem_we_o;
  logic load_valid_o;
  logic load_exception_o;
  logic store_valid_o;
  logic store_exception_o;
  lsu_pkg::lsu_op_e   lsu_op_i;
  lsu_pkg::xlen_t     operand_a_i;
  lsu_pkg::xlen_t     imm_i;
  lsu_pkg::xlen_t     store_data_i;
  lsu_pkg::trans_id_t trans_id_i;
  lsu_pkg::xlen_t     mem_addr_o;
  lsu_pkg::xlen_t     mem_wdata_o;
  lsu_pkg::be_t       mem_be_o;
  lsu_pkg::xlen_t     mem_rdata_i;
  lsu_pkg::trans_id_t load_trans_id_o;
  lsu_pkg::xlen_t     load_result_o;
  lsu_pkg::cause_t    load_cause_o;
  lsu_pkg::trans_id_t store_trans_id_o;
  lsu_pkg::cause_t    store_cause_o;

  lsu_pkg::xlen_t mem     [MEM_WORDS];
  lsu_pkg::xlen_t ref_mem [MEM_WORDS];
  expect_t        expected_q [$];
  int             seed = 32'hdafbaca1;
  int             issued = 0;
  int             received = 0;
  int             cycle_count = 0;

  tb_clock_gen i_clock_gen (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  load_store_unit #(
    .ResultPipeDepth (PIPE_DEPTH)
  ) DUT (
    .clk_i, .rst_ni, .lsu_valid_i, .lsu_op_i, .operand_a_i, .imm_i, .store_data_i,
    .trans_id_i, .lsu_ready_o, .mem_req_o, .mem_ack_i, .mem_addr_o, .mem_wdata_o,
    .mem_we_o, .mem_be_o, .mem_rdata_i, .load_valid_o, .load_trans_id_o,
    .load_result_o, .load_exception_o, .load_cause_o, .store_valid_o,
    .store_trans_id_o, .store_exception_o, .store_cause_o
  );

  task automatic report_failure(string reason);
    $display("%s", reason);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check_value(string name, lsu_pkg::xlen_t got, lsu_pkg::xlen_t exp);
    assert (got === exp)
      else report_failure($sformatf("Error: time %0t, %s got %h, expected %h",
                                    $time, name, got, exp));
  endtask

  function automatic int access_size(lsu_pkg::lsu_op_e op);
    case (op)
      lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::SB: return 1;
      lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH: return 2;
      default:                                return 4;
    endcase
  endfunction

  function automatic logic is_load_op(lsu_pkg::lsu_op_e op);
    return op inside {lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::LW};
  endfunction

  // Pick the addressed byte or halfword, then extend it
  function automatic lsu_pkg::xlen_t load_value(lsu_pkg::lsu_op_e op, lsu_pkg::xlen_t word,
                                                logic [1:0] ofs);
    logic [7:0]  b;
    logic [15:0] h;
    b = word[8*ofs +: 8];
    h = ofs[1] ? word[31:16] : word[15:0];
    case (op)
      lsu_pkg::LB:  return {{24{b[7]}}, b};
      lsu_pkg::LBU: return {24'h0, b};
      lsu_pkg::LH:  return {{16{h[15]}}, h};
      lsu_pkg::LHU: return {16'h0, h};
      default:      return word;
    endcase
  endfunction

  // --------------------
  // Reference model
  // --------------------
  task automatic record_expectation(lsu_pkg::lsu_op_e op, lsu_pkg::xlen_t addr,
                                    lsu_pkg::xlen_t data, lsu_pkg::trans_id_t tag);
    expect_t     e;
    int          size;
    int unsigned idx;
    logic [1:0]  ofs;
    size        = access_size(op);
    ofs         = addr[1:0];
    idx         = (addr >> 2) % MEM_WORDS;
    e.is_load   = is_load_op(op);
    e.tag       = tag;
    e.exception = (addr % size) != 0;
    e.cause     = e.is_load ? lsu_pkg::CAUSE_LD_MISALIGNED : lsu_pkg::CAUSE_ST_MISALIGNED;
    e.data      = '0;
    if (e.exception) begin
      e.data = addr;
    end else if (e.is_load) begin
      e.data = load_value(op, ref_mem[idx], ofs);
    end else begin
      for (int i = 0; i < size; i++) begin
        ref_mem[idx][8*(ofs+i) +: 8] = data[8*i +: 8];
      end
    end
    expected_q.push_back(e);
  endtask

  // Holds the operation until an edge with ready high takes it
  task automatic issue_op(lsu_pkg::lsu_op_e op, lsu_pkg::xlen_t base, lsu_pkg::xlen_t imm,
                          lsu_pkg::xlen_t data);
    logic accepted;
    lsu_valid_i  = 1'b1;
    lsu_op_i     = op;
    operand_a_i  = base;
    imm_i        = imm;
    store_data_i = data;
    trans_id_i   = lsu_pkg::trans_id_t'(issued);
    accepted     = 1'b0;
    while (!accepted) begin
      accepted = lsu_ready_o;
      @(posedge clk_i);
      #1;
    end
    record_expectation(op, base + imm, data, trans_id_i);
    issued++;
    lsu_valid_i = 1'b0;
  endtask

  task automatic random_op();
    lsu_pkg::lsu_op_e op;
    lsu_pkg::xlen_t   addr;
    lsu_pkg::xlen_t   imm;
    int               gap;
    case ($unsigned($random(seed)) % 8)
      0:       op = lsu_pkg::LB;
      1:       op = lsu_pkg::LBU;
      2:       op = lsu_pkg::LH;
      3:       op = lsu_pkg::LHU;
      4:       op = lsu_pkg::LW;
      5:       op = lsu_pkg::SB;
      6:       op = lsu_pkg::SH;
      default: op = lsu_pkg::SW;
    endcase
    addr = $unsigned($random(seed)) % (MEM_WORDS * 4);
    // Aligned except for one draw in eight
    if ($unsigned($random(seed)) % 8 != 0) begin
      addr = addr & ~lsu_pkg::xlen_t'(access_size(op) - 1);
    end
    imm = $random(seed) % 64;
    issue_op(op, addr - imm, imm, $random(seed));
    gap = $unsigned($random(seed)) % 3;
    repeat (gap) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic check_result();
    expect_t e;
    assert (!(load_valid_o && store_valid_o))
      else report_failure("Load and store results strobed in the same cycle");
    assert (expected_q.size() != 0)
      else report_failure("Result arrived with no operation outstanding");
    e = expected_q.pop_front();
    if (load_valid_o) begin
      check_value("load_valid_o", load_valid_o, e.is_load);
      check_value("load_trans_id_o", load_trans_id_o, e.tag);
      check_value("load_exception_o", load_exception_o, e.exception);
      check_value("load_result_o", load_result_o, e.data);
      if (e.exception) begin
        check_value("load_cause_o", load_cause_o, e.cause);
      end
    end else begin
      check_value("store_valid_o", store_valid_o, !e.is_load);
      check_value("store_trans_id_o", store_trans_id_o, e.tag);
      check_value("store_exception_o", store_exception_o, e.exception);
      if (e.exception) begin
        check_value("store_cause_o", store_cause_o, e.cause);
      end
    end
    received++;
  endtask

  // --------------------
  // Memory model
  // --------------------
  initial begin : fill_memories
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i]     = (i * 32'h0101_0101) ^ (i << 13) ^ 32'ha5c3_0f96;
      ref_mem[i] = mem[i];
    end
  end

  initial begin : memory_model
    int unsigned delay;
    int unsigned idx;
    mem_ack_i   = 1'b0;
    mem_rdata_i = '0;
    forever begin
      @(posedge clk_i);
      #1;
      if (rst_ni && mem_req_o) begin
        delay = $unsigned($random(seed)) % (MAX_ACK_DELAY + 1);
        repeat (delay) begin
          @(posedge clk_i);
          #1;
        end
        idx = (mem_addr_o >> 2) % MEM_WORDS;
        if (mem_we_o) begin
          for (int i = 0; i < 4; i++) begin
            if (mem_be_o[i]) begin
              mem[idx][8*i +: 8] = mem_wdata_o[8*i +: 8];
            end
          end
        end else begin
          mem_rdata_i = mem[idx];
        end
        mem_ack_i = 1'b1;
        do begin
          @(posedge clk_i);
          #1;
        end while (mem_req_o);
        // Ack is held a random time after the request falls
        delay = $unsigned($random(seed)) % (MAX_ACK_DELAY + 1);
        repeat (delay) begin
          @(posedge clk_i);
          #1;
        end
        mem_ack_i = 1'b0;
      end
    end
  end

  // Outputs are compared at the falling edge
  always @(negedge clk_i) begin
    if (rst_ni && (load_valid_o || store_valid_o)) begin
      check_result();
    end
    if (DUT.i_lsu_checker.fail_count != 0) begin
      report_failure("A protocol assertion in the bound checker failed");
    end
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      report_failure("Timeout, not all results arrived within the cycle limit");
    end
  end

  // --------------------
  // Stimulus
  // --------------------
  initial begin : stimulus
    lsu_valid_i  = 1'b0;
    lsu_op_i     = lsu_pkg::LW;
    operand_a_i  = '0;
    imm_i        = '0;
    store_data_i = '0;
    trans_id_i   = '0;
    wait (rst_ni);
    @(posedge clk_i);
    #1;
    // Store then load the same word through a different base
    issue_op(lsu_pkg::SW, 32'h40, 32'h10, 32'hcafe_f00d);
    issue_op(lsu_pkg::LW, 32'h60, 32'hffff_fff0, '0);
    // Sub-word lanes with sign and zero extension
    issue_op(lsu_pkg::SB, 32'h50, 32'h1, 32'h85);
    issue_op(lsu_pkg::LB, 32'h52, 32'hffff_ffff, '0);
    issue_op(lsu_pkg::LBU, 32'h51, '0, '0);
    issue_op(lsu_pkg::SH, 32'h50, 32'h2, 32'h8001);
    issue_op(lsu_pkg::LH, 32'h52, '0, '0);
    issue_op(lsu_pkg::LHU, 32'h4e, 32'h4, '0);
    issue_op(lsu_pkg::LW, 32'h50, '0, '0);
    // Misaligned loads and stores
    issue_op(lsu_pkg::LH, 32'h53, '0, '0);
    issue_op(lsu_pkg::LW, 32'h50, 32'h2, '0);
    issue_op(lsu_pkg::SW, 32'h41, '0, 32'h1234_5678);
    issue_op(lsu_pkg::SH, 32'h44, 32'h1, 32'hbeef);
    while (issued < NUM_OPS) begin
      random_op();
    end
    wait (received == issued);
    @(posedge clk_i);
    if (DUT.i_lsu_checker.fail_count != 0) begin
      report_failure("A protocol assertion in the bound checker failed");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule
